// File: source/icache_pkg.sv
// ********************
// geometry of the instruction cache and the prefetch queue
// direct mapped, one 64-bit word per line, byte addressed fetch
// PFETCH_NUM must stay a power of two matching PTR_W
// ********************
package icache_pkg;

	// address split: tag | index | byte offset
	localparam int ADDR_W   = 64;
	localparam int OFFSET_W = 3;
	localparam int IDX_W    = 5;
	localparam int TAG_W    = ADDR_W - IDX_W - OFFSET_W;
	localparam int LINE_W   = 64;

	// prefetch queue
	localparam int PFETCH_NUM = 4;
	localparam int PTR_W      = 2;
	localparam logic [ADDR_W-1:0] STEP = 64'd8;

	// demand miss controller
	typedef enum logic [1:0] {
		IDLE      = 2'd0,
		MISS_REQ  = 2'd1,
		MISS_WAIT = 2'd2
	} ctrl_state_e;

endpackage

// File: source/mem_bus_pkg.sv
// ********************
// split transaction memory bus
// a nonzero response tag accepts the command in that cycle
// tag 0 never names a transaction
// ********************
package mem_bus_pkg;

	// only loads are issued by the fetch side
	typedef enum logic [1:0] {
		BUS_NONE = 2'd0,
		BUS_LOAD = 2'd1
	} bus_cmd_e;

	// transaction tag, also carried back with the data
	localparam int MEM_TAG_W = 4;

endpackage

// File: source/rps4.sv
// ********************
// rotating priority select over four requests
// search starts at ptr_i and wraps, at most one grant
// ********************
`timescale 1ns/1ps

module rps4 (
	input  logic                         en_i,
	input  logic [icache_pkg::PFETCH_NUM-1:0] req_i,
	input  logic [icache_pkg::PTR_W-1:0]      ptr_i,
	output logic [icache_pkg::PFETCH_NUM-1:0] gnt_o
);

	logic                         found;
	logic [icache_pkg::PTR_W-1:0] idx;

	// walk the ring from the pointer, first active request wins
	always_comb begin
		gnt_o = '0;
		found = 1'b0;
		idx   = ptr_i;
		if (en_i) begin
			for (int k = 0; k < icache_pkg::PFETCH_NUM; k++) begin
				// index wraps in PTR_W bits
				idx = ptr_i + k[icache_pkg::PTR_W-1:0];
				if (!found && req_i[idx]) begin
					gnt_o[idx] = 1'b1;
					found      = 1'b1;
				end
			end
		end
	end

endmodule

// File: source/prefetch.sv
// ********************
// four entry stream prefetcher, runs ahead in 8-byte steps
// only issues while pf_en_i is high, reloads when it is low
// a probe hit or a late tag after reload is dropped silently
// ********************
`timescale 1ns/1ps

module prefetch (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic [mem_bus_pkg::MEM_TAG_W-1:0]     mem_tag_i,
	input  logic [mem_bus_pkg::MEM_TAG_W-1:0]     mem_response_i,
	input  logic                                  cache_hit_i,
	input  logic                                  probe_hit_i,
	input  logic                                  flush_i,
	input  logic [icache_pkg::ADDR_W-1:0]         fetch_addr_i,
	input  logic                                  pf_en_i,
	output logic                                  soft_hit_o,
	output logic                                  prefetching_o,
	output logic                                  wr_en_o,
	output logic [icache_pkg::TAG_W-1:0]          wr_tag_o,
	output logic [icache_pkg::IDX_W-1:0]          wr_idx_o,
	output logic [icache_pkg::TAG_W-1:0]          rd_tag_o,
	output logic [icache_pkg::IDX_W-1:0]          rd_idx_o,
	output logic [icache_pkg::ADDR_W-1:0]         mem_addr_o,
	output mem_bus_pkg::bus_cmd_e                 mem_command_o
);

	// ********************
	// queue state
	// ********************
	logic [icache_pkg::PFETCH_NUM-1:0][icache_pkg::ADDR_W-1:0]     addr_r, addr_nxt;
	logic [icache_pkg::PFETCH_NUM-1:0][mem_bus_pkg::MEM_TAG_W-1:0] tag_r, tag_nxt;
	logic [icache_pkg::PFETCH_NUM-1:0] vld_r, vld_nxt;
	logic [icache_pkg::PFETCH_NUM-1:0] sent_r, sent_nxt;
	// msb of each pointer is the wrap bit
	logic [icache_pkg::PTR_W:0] head_r, head_nxt;
	logic [icache_pkg::PTR_W:0] tail_r, tail_nxt;
	logic [icache_pkg::PTR_W-1:0] tail_idx, tail_prev;
	logic full, empty, reload, alloc, ack;
	logic [icache_pkg::ADDR_W-1:0] new_addr;

	// selection and fill
	logic [icache_pkg::PFETCH_NUM-1:0] req, rr_gnt, smiss_gnt, smiss_gnt_r, smiss_live, sel_gnt;
	logic [icache_pkg::PTR_W-1:0]  sel_ptr, fill_ptr;
	logic [icache_pkg::ADDR_W-1:0] sel_addr, fill_addr;
	logic pfetching, fill_hit;

	assign reload    = ~pf_en_i | flush_i;
	assign ack       = (mem_response_i != '0);
	assign tail_idx  = tail_r[icache_pkg::PTR_W-1:0];
	assign tail_prev = tail_idx - 1'b1;
	assign full  = (head_r[icache_pkg::PTR_W] != tail_r[icache_pkg::PTR_W]) &&
		(head_r[icache_pkg::PTR_W-1:0] == tail_idx);
	assign empty = (head_r == tail_r);
	assign alloc = cache_hit_i && ~full;
	// next line follows the youngest entry, or the fetch address when empty
	assign new_addr = empty ? fetch_addr_i + icache_pkg::STEP : addr_r[tail_prev] + icache_pkg::STEP;

	// ********************
	// issue selection
	// ********************
	assign req = vld_r & ~sent_r;

	rps4 rps4_issue (
		.en_i  (pf_en_i),
		.req_i (req),
		.ptr_i (head_r[icache_pkg::PTR_W-1:0]),
		.gnt_o (rr_gnt)
	);

	// fetch side missed on a queued line, compare by line address
	always_comb begin
		soft_hit_o = 1'b0;
		smiss_gnt  = '0;
		for (int i = 0; i < icache_pkg::PFETCH_NUM; i++) begin
			if (vld_r[i] && addr_r[i][icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W] ==
				fetch_addr_i[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W]) begin
				soft_hit_o = 1'b1;
				if (~cache_hit_i && ~sent_r[i] && ~reload)
					smiss_gnt[i] = 1'b1;
			end
		end
	end

	// registered soft miss wins, masked so a sent entry is not reissued
	assign smiss_live = smiss_gnt_r & req;
	assign sel_gnt    = (|smiss_live) ? smiss_live : rr_gnt;

	always_comb begin
		sel_ptr  = '0;
		sel_addr = '0;
		for (int i = 0; i < icache_pkg::PFETCH_NUM; i++) begin
			if (sel_gnt[i]) begin
				sel_ptr  = i[icache_pkg::PTR_W-1:0];
				sel_addr = addr_r[i];
			end
		end
	end

	// command and probe go out together
	assign pfetching     = (|sel_gnt) && pf_en_i && ~flush_i;
	assign prefetching_o = pfetching;
	assign mem_command_o = pfetching ? mem_bus_pkg::BUS_LOAD : mem_bus_pkg::BUS_NONE;
	assign mem_addr_o    = sel_addr;
	assign {rd_tag_o, rd_idx_o} = sel_addr[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W];

	// ********************
	// fill from returning tags
	// ********************
	always_comb begin
		fill_hit  = 1'b0;
		fill_ptr  = '0;
		fill_addr = '0;
		for (int i = 0; i < icache_pkg::PFETCH_NUM; i++) begin
			if (mem_tag_i != '0 && vld_r[i] && sent_r[i] && tag_r[i] == mem_tag_i) begin
				fill_hit  = 1'b1;
				fill_ptr  = i[icache_pkg::PTR_W-1:0];
				fill_addr = addr_r[i];
			end
		end
	end

	assign wr_en_o = fill_hit;
	assign {wr_tag_o, wr_idx_o} = fill_addr[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W];

	// entry next state
	always_comb begin
		addr_nxt = addr_r;
		vld_nxt  = vld_r;
		sent_nxt = sent_r;
		tag_nxt  = tag_r;
		if (reload) begin
			for (int i = 0; i < icache_pkg::PFETCH_NUM; i++) begin
				addr_nxt[i] = fetch_addr_i + icache_pkg::STEP * (i + 1);
				vld_nxt[i]  = 1'b1;
				sent_nxt[i] = 1'b0;
				tag_nxt[i]  = '0;
			end
		end else begin
			// line already cached, retire without waiting
			if (pfetching && probe_hit_i) begin
				vld_nxt[sel_ptr]  = 1'b0;
				sent_nxt[sel_ptr] = 1'b0;
				tag_nxt[sel_ptr]  = '0;
			end else if (pfetching && ack) begin
				sent_nxt[sel_ptr] = 1'b1;
				tag_nxt[sel_ptr]  = mem_response_i;
			end
			if (fill_hit) begin
				vld_nxt[fill_ptr]  = 1'b0;
				sent_nxt[fill_ptr] = 1'b0;
				tag_nxt[fill_ptr]  = '0;
			end
			if (alloc) begin
				addr_nxt[tail_idx] = new_addr;
				vld_nxt[tail_idx]  = 1'b1;
				sent_nxt[tail_idx] = 1'b0;
				tag_nxt[tail_idx]  = '0;
			end
		end
	end

	// pointers, a reload leaves the queue full
	always_comb begin
		head_nxt = head_r;
		tail_nxt = tail_r;
		if (reload) begin
			head_nxt = '0;
			tail_nxt = {1'b1, {icache_pkg::PTR_W{1'b0}}};
		end else begin
			if (~empty && ~vld_r[head_r[icache_pkg::PTR_W-1:0]])
				head_nxt = head_r + 1'b1;
			if (alloc)
				tail_nxt = tail_r + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_r       <= '0;
			sent_r      <= '0;
			tag_r       <= '0;
			head_r      <= '0;
			tail_r      <= '0;
			smiss_gnt_r <= '0;
		end else begin
			vld_r       <= vld_nxt;
			sent_r      <= sent_nxt;
			tag_r       <= tag_nxt;
			head_r      <= head_nxt;
			tail_r      <= tail_nxt;
			smiss_gnt_r <= smiss_gnt;
		end
	end

	always_ff @(posedge clk) begin
		addr_r <= addr_nxt;
	end

endmodule

// File: source/icache_mem.sv
// ********************
// direct mapped line store, 32 lines of one word
// lookups are combinational, write lands at the clock edge
// no bypass from a write to a read in the same cycle
// ********************
`timescale 1ns/1ps

module icache_mem (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [icache_pkg::ADDR_W-1:0] rd_addr_i,
	input  logic [icache_pkg::TAG_W-1:0]  probe_tag_i,
	input  logic [icache_pkg::IDX_W-1:0]  probe_idx_i,
	input  logic                          wr_en_i,
	input  logic [icache_pkg::TAG_W-1:0]  wr_tag_i,
	input  logic [icache_pkg::IDX_W-1:0]  wr_idx_i,
	input  logic [icache_pkg::LINE_W-1:0] wr_data_i,
	output logic                          hit_o,
	output logic [icache_pkg::LINE_W-1:0] data_o,
	output logic                          probe_hit_o
);

	logic [2**icache_pkg::IDX_W-1:0]                            valid_r;
	logic [2**icache_pkg::IDX_W-1:0][icache_pkg::TAG_W-1:0]     tag_r;
	logic [2**icache_pkg::IDX_W-1:0][icache_pkg::LINE_W-1:0]    data_r;

	logic [icache_pkg::TAG_W-1:0] rd_tag;
	logic [icache_pkg::IDX_W-1:0] rd_idx;

	assign {rd_tag, rd_idx} = rd_addr_i[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W];

	// fetch side
	assign hit_o  = valid_r[rd_idx] && (tag_r[rd_idx] == rd_tag);
	assign data_o = data_r[rd_idx];

	// prefetch probe
	assign probe_hit_o = valid_r[probe_idx_i] && (tag_r[probe_idx_i] == probe_tag_i);

	always_ff @(posedge clk) begin
		if (rst)
			valid_r <= '0;
		else if (wr_en_i)
			valid_r[wr_idx_i] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (wr_en_i) begin
			tag_r[wr_idx_i]  <= wr_tag_i;
			data_r[wr_idx_i] <= wr_data_i;
		end
	end

endmodule

// File: source/icache_ctrl.sv
// ********************
// demand miss FSM and memory bus owner
// one demand load in flight, the prefetcher gets the bus otherwise
// a soft miss waits for the prefetch fill instead of loading
// ********************
`timescale 1ns/1ps

module icache_ctrl (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [icache_pkg::ADDR_W-1:0]     fetch_addr_i,
	input  logic                              fetch_en_i,
	input  logic                              flush_i,
	input  logic                              hit_i,
	input  logic                              pf_soft_hit_i,
	input  logic [mem_bus_pkg::MEM_TAG_W-1:0] mem_response_i,
	input  logic [mem_bus_pkg::MEM_TAG_W-1:0] mem_tag_i,
	input  mem_bus_pkg::bus_cmd_e             pf_command_i,
	input  logic [icache_pkg::ADDR_W-1:0]     pf_addr_i,
	input  logic                              pf_wr_en_i,
	input  logic [icache_pkg::TAG_W-1:0]      pf_wr_tag_i,
	input  logic [icache_pkg::IDX_W-1:0]      pf_wr_idx_i,
	output logic                              pf_en_o,
	output mem_bus_pkg::bus_cmd_e             mem_command_o,
	output logic [icache_pkg::ADDR_W-1:0]     mem_addr_o,
	output logic                              wr_en_o,
	output logic [icache_pkg::TAG_W-1:0]      wr_tag_o,
	output logic [icache_pkg::IDX_W-1:0]      wr_idx_o,
	output logic                              fetch_valid_o
);

	icache_pkg::ctrl_state_e state_r, state_nxt;
	logic [icache_pkg::ADDR_W-1:0]     miss_addr_r;
	logic [mem_bus_pkg::MEM_TAG_W-1:0] dem_tag_r;
	logic miss, dem_fill, in_req;

	assign in_req   = (state_r == icache_pkg::MISS_REQ);
	// hard miss only, a queued line is left to the prefetcher
	assign miss     = fetch_en_i && ~flush_i && ~hit_i && ~pf_soft_hit_i;
	assign dem_fill = (state_r == icache_pkg::MISS_WAIT) && (mem_tag_i != '0) &&
		(mem_tag_i == dem_tag_r);

	always_comb begin
		state_nxt = state_r;
		case (state_r)
			icache_pkg::IDLE:      if (miss) state_nxt = icache_pkg::MISS_REQ;
			icache_pkg::MISS_REQ:  if (mem_response_i != '0) state_nxt = icache_pkg::MISS_WAIT;
			icache_pkg::MISS_WAIT: if (dem_fill) state_nxt = icache_pkg::IDLE;
			default:               state_nxt = icache_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_r   <= icache_pkg::IDLE;
			dem_tag_r <= '0;
		end else begin
			state_r <= state_nxt;
			if (in_req && mem_response_i != '0)
				dem_tag_r <= mem_response_i;
		end
	end

	// miss address held until the fill
	always_ff @(posedge clk) begin
		if (state_r == icache_pkg::IDLE && miss)
			miss_addr_r <= fetch_addr_i;
	end

	// ********************
	// bus and write port sharing
	// ********************
	assign pf_en_o       = fetch_en_i && ~in_req;
	assign mem_command_o = in_req ? mem_bus_pkg::BUS_LOAD : pf_command_i;
	assign mem_addr_o    = in_req ? miss_addr_r : pf_addr_i;

	assign wr_en_o  = dem_fill | pf_wr_en_i;
	assign wr_tag_o = dem_fill ? miss_addr_r[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W] : pf_wr_tag_i;
	assign wr_idx_o = dem_fill ? miss_addr_r[icache_pkg::OFFSET_W +: icache_pkg::IDX_W] : pf_wr_idx_i;

	assign fetch_valid_o = fetch_en_i && hit_i;

endmodule

// File: source/icache_top.sv
// ********************
// instruction fetch cache with stream prefetch
// memory must hand out distinct nonzero tags per outstanding load
// ********************
`timescale 1ns/1ps

module icache_top (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [icache_pkg::ADDR_W-1:0]     fetch_addr_i,
	input  logic                              fetch_en_i,
	input  logic                              flush_i,
	input  logic [mem_bus_pkg::MEM_TAG_W-1:0] mem_response_i,
	input  logic [mem_bus_pkg::MEM_TAG_W-1:0] mem_tag_i,
	input  logic [icache_pkg::LINE_W-1:0]     mem_data_i,
	output logic [icache_pkg::LINE_W-1:0]     fetch_data_o,
	output logic                              fetch_valid_o,
	output mem_bus_pkg::bus_cmd_e             mem_command_o,
	output logic [icache_pkg::ADDR_W-1:0]     mem_addr_o
);

	logic hit, pf_probe_hit, pf_soft_hit, pf_en, pf_wr_en, wr_en;
	logic [icache_pkg::TAG_W-1:0]  pf_wr_tag, pf_rd_tag, wr_tag;
	logic [icache_pkg::IDX_W-1:0]  pf_wr_idx, pf_rd_idx, wr_idx;
	logic [icache_pkg::ADDR_W-1:0] pf_mem_addr;
	mem_bus_pkg::bus_cmd_e         pf_mem_command;

	icache_ctrl u_ctrl (
		.clk            (clk),
		.rst            (rst),
		.fetch_addr_i   (fetch_addr_i),
		.fetch_en_i     (fetch_en_i),
		.flush_i        (flush_i),
		.hit_i          (hit),
		.pf_soft_hit_i  (pf_soft_hit),
		.mem_response_i (mem_response_i),
		.mem_tag_i      (mem_tag_i),
		.pf_command_i   (pf_mem_command),
		.pf_addr_i      (pf_mem_addr),
		.pf_wr_en_i     (pf_wr_en),
		.pf_wr_tag_i    (pf_wr_tag),
		.pf_wr_idx_i    (pf_wr_idx),
		.pf_en_o        (pf_en),
		.mem_command_o  (mem_command_o),
		.mem_addr_o     (mem_addr_o),
		.wr_en_o        (wr_en),
		.wr_tag_o       (wr_tag),
		.wr_idx_o       (wr_idx),
		.fetch_valid_o  (fetch_valid_o)
	);

	// line data always comes straight off the bus
	icache_mem u_mem (
		.clk         (clk),
		.rst         (rst),
		.rd_addr_i   (fetch_addr_i),
		.probe_tag_i (pf_rd_tag),
		.probe_idx_i (pf_rd_idx),
		.wr_en_i     (wr_en),
		.wr_tag_i    (wr_tag),
		.wr_idx_i    (wr_idx),
		.wr_data_i   (mem_data_i),
		.hit_o       (hit),
		.data_o      (fetch_data_o),
		.probe_hit_o (pf_probe_hit)
	);

	prefetch u_prefetch (
		.clk            (clk),
		.rst            (rst),
		.mem_tag_i      (mem_tag_i),
		.mem_response_i (mem_response_i),
		.cache_hit_i    (hit),
		.probe_hit_i    (pf_probe_hit),
		.flush_i        (flush_i),
		.fetch_addr_i   (fetch_addr_i),
		.pf_en_i        (pf_en),
		.soft_hit_o     (pf_soft_hit),
		.prefetching_o  (),
		.wr_en_o        (pf_wr_en),
		.wr_tag_o       (pf_wr_tag),
		.wr_idx_o       (pf_wr_idx),
		.rd_tag_o       (pf_rd_tag),
		.rd_idx_o       (pf_rd_idx),
		.mem_addr_o     (pf_mem_addr),
		.mem_command_o  (pf_mem_command)
	);

endmodule

// File: tests/tb_clock.sv
// ********************
// free running clock, 10 ns period
// ********************
`timescale 1ns/1ps

module tb_clock (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
	end

	always #5 clk_o = ~clk_o;

endmodule

// File: tests/icache_checker.sv
// ********************
// watches the fetch port and the memory bus
// compares fetch data against the line pattern
// samples at the rising edge, before any register updates
// ********************
`timescale 1ns/1ps

module icache_checker (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              fetch_en_i,
	input  logic [icache_pkg::ADDR_W-1:0]     fetch_addr_i,
	input  logic                              fetch_valid_i,
	input  logic [icache_pkg::LINE_W-1:0]     fetch_data_i,
	input  mem_bus_pkg::bus_cmd_e             mem_command_i,
	input  logic [icache_pkg::ADDR_W-1:0]     mem_addr_i,
	input  logic [mem_bus_pkg::MEM_TAG_W-1:0] mem_response_i
);

	int chk_test = 0;
	int err_test = 0;
	int chk_total = 0;
	int err_total = 0;
	int tests = 0;

	// stalled load for the line being fetched, seen in the previous cycle
	logic                          held_vld = 1'b0;
	logic [icache_pkg::ADDR_W-1:0] held_addr;
	logic [icache_pkg::ADDR_W-1:0] held_fetch;

	// expected memory content, line address mixed with a constant
	function automatic logic [icache_pkg::LINE_W-1:0] line_pattern(
		input logic [icache_pkg::ADDR_W-1:0] addr);
		logic [icache_pkg::ADDR_W-1:0] line_addr;
		line_addr = {addr[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W],
			{icache_pkg::OFFSET_W{1'b0}}};
		return line_addr ^ 64'ha5c3_0f1e_5a3c_f0e1;
	endfunction

	task automatic plain_fail(input string what);
		$display("%0t: %s", $time, what);
		err_test++;
	endtask

	// fetch data compare
	always @(posedge clk) begin
		if (!rst && fetch_valid_i) begin
			chk_test++;
			if (!fetch_en_i)
				plain_fail("fetch valid rose while fetch was disabled");
			else if (fetch_data_i !== line_pattern(fetch_addr_i)) begin
				$display("ERR fetch_data_o addr %h expected %h got %h",
					fetch_addr_i, line_pattern(fetch_addr_i), fetch_data_i);
				err_test++;
			end
		end
	end

	// a load for the waiting line stays on the bus until accepted
	always @(posedge clk) begin
		if (!rst && held_vld && fetch_addr_i == held_fetch) begin
			chk_test++;
			if (mem_command_i !== mem_bus_pkg::BUS_LOAD) begin
				$display("ERR mem_command_o expected %h got %h",
					mem_bus_pkg::BUS_LOAD, mem_command_i);
				err_test++;
			end else if (mem_addr_i !== held_addr) begin
				$display("ERR mem_addr_o expected %h got %h", held_addr, mem_addr_i);
				err_test++;
			end
		end
		held_vld <= !rst && fetch_en_i && !fetch_valid_i &&
			mem_command_i == mem_bus_pkg::BUS_LOAD && mem_response_i == '0 &&
			mem_addr_i[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W] ==
			fetch_addr_i[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W];
		held_addr  <= mem_addr_i;
		held_fetch <= fetch_addr_i;
	end

	// bus and fetch port quiet after reset
	task automatic check_quiet();
		chk_test++;
		if (mem_command_i !== mem_bus_pkg::BUS_NONE) begin
			$display("ERR mem_command_o expected %h got %h",
				mem_bus_pkg::BUS_NONE, mem_command_i);
			err_test++;
		end
		if (fetch_valid_i !== 1'b0) begin
			$display("ERR fetch_valid_o expected %h got %h", 1'b0, fetch_valid_i);
			err_test++;
		end
	endtask

	task automatic end_test(input string name);
		$display("test %s: %0d checks, %0d errors", name, chk_test, err_test);
		chk_total += chk_test;
		err_total += err_test;
		chk_test = 0;
		err_test = 0;
		tests++;
	endtask

	task automatic summary();
		$display("%0d tests, %0d checks, %0d errors", tests, chk_total, err_total);
	endtask

endmodule

// File: tests/icache_tb.sv
// ********************
// top testbench with a tagged split transaction memory model
// up to 15 loads in flight, one tag returned per cycle
// ********************
`timescale 1ns/1ps

module icache_tb;

	localparam int N_SEQ = 64;
	localparam int N_JUMP = 40;
	localparam int N_STALL = 48;
	localparam int N_DIS = 16;
	localparam int FETCH_LIMIT = 200;
	localparam int N_FETCH = N_SEQ + 8 + N_JUMP + N_STALL + N_DIS;

	logic clk, rst, fetch_en_i, flush_i, fetch_valid_o;
	logic [icache_pkg::ADDR_W-1:0] fetch_addr_i, mem_addr_o;
	logic [mem_bus_pkg::MEM_TAG_W-1:0] mem_response_i, mem_tag_i;
	logic [icache_pkg::LINE_W-1:0] mem_data_i, fetch_data_o;
	mem_bus_pkg::bus_cmd_e mem_command_o;

	int stall_pct = 20;
	int mem_cycle = 0;
	logic [15:0] busy;
	logic [mem_bus_pkg::MEM_TAG_W-1:0] pend_tag[$];
	logic [icache_pkg::ADDR_W-1:0] pend_addr[$];
	int pend_due[$];

	tb_clock clock_gen (.clk_o(clk));

	icache_top dut (
		.clk(clk), .rst(rst), .fetch_addr_i(fetch_addr_i), .fetch_en_i(fetch_en_i),
		.flush_i(flush_i), .mem_response_i(mem_response_i), .mem_tag_i(mem_tag_i),
		.mem_data_i(mem_data_i), .fetch_data_o(fetch_data_o),
		.fetch_valid_o(fetch_valid_o), .mem_command_o(mem_command_o),
		.mem_addr_o(mem_addr_o)
	);

	icache_checker chk (
		.clk(clk), .rst(rst), .fetch_en_i(fetch_en_i), .fetch_addr_i(fetch_addr_i),
		.fetch_valid_i(fetch_valid_o), .fetch_data_i(fetch_data_o),
		.mem_command_i(mem_command_o), .mem_addr_i(mem_addr_o),
		.mem_response_i(mem_response_i)
	);

	// ********************
	// memory model
	// ********************
	// acts 1 ns after the falling edge, once the command has settled
	always @(negedge clk) begin
		int pick, ri;
		#1;
		pick = 0;
		ri = -1;
		mem_response_i = '0;
		mem_tag_i = '0;
		mem_data_i = '0;
		if (rst) begin
			busy = '0;
			pend_tag.delete();
			pend_addr.delete();
			pend_due.delete();
		end else begin
			if (mem_command_o == mem_bus_pkg::BUS_LOAD && ($urandom % 100) >= stall_pct) begin
				for (int t = 15; t >= 1; t--)
					if (!busy[t])
						pick = t;
			end
			// the tag returned below is only reused from the next cycle on
			for (int i = 0; i < pend_due.size(); i++)
				if (ri < 0 && pend_due[i] <= mem_cycle)
					ri = i;
			if (pick != 0) begin
				busy[pick] = 1'b1;
				mem_response_i = pick[mem_bus_pkg::MEM_TAG_W-1:0];
				pend_tag.push_back(pick[mem_bus_pkg::MEM_TAG_W-1:0]);
				pend_addr.push_back(mem_addr_o);
				pend_due.push_back(mem_cycle + 2 + int'($urandom % 5));
			end
			if (ri >= 0) begin
				mem_tag_i = pend_tag[ri];
				mem_data_i = chk.line_pattern(pend_addr[ri]);
				busy[pend_tag[ri]] = 1'b0;
				pend_tag.delete(ri);
				pend_addr.delete(ri);
				pend_due.delete(ri);
			end
			mem_cycle++;
		end
	end

	// present one address and wait for fetch_valid_o
	task automatic fetch(input logic [icache_pkg::ADDR_W-1:0] addr, input logic flush,
		output int cycles);
		logic done;
		done = 1'b0;
		cycles = 0;
		@(negedge clk);
		fetch_addr_i = addr;
		flush_i = flush;
		while (!done) begin
			@(posedge clk);
			cycles++;
			if (fetch_valid_o)
				done = 1'b1;
			else if (cycles >= FETCH_LIMIT) begin
				chk.plain_fail($sformatf("fetch at %h never completed", addr));
				done = 1'b1;
			end else begin
				@(negedge clk);
				flush_i = 1'b0;
			end
		end
	endtask

	// watchdog
	initial begin
		repeat (N_FETCH * 40 + 200) @(posedge clk);
		$display("timeout: the tests did not finish in time");
		$display("Something failed");
		$finish;
	end

	initial begin
		int n;
		logic [icache_pkg::ADDR_W-1:0] a;
		void'($urandom(32'he2f9_377c));
		rst = 1'b1;
		// fetch enabled but flushed, so only the reset state keeps bus and valid quiet
		fetch_en_i = 1'b1;
		flush_i = 1'b1;
		fetch_addr_i = '0;
		mem_response_i = '0;
		mem_tag_i = '0;
		mem_data_i = '0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		repeat (3) begin
			@(posedge clk);
			chk.check_quiet();
		end
		chk.end_test("reset");

		fetch_en_i = 1'b1;
		for (int i = 0; i < N_SEQ; i++)
			fetch(64'h1000 + 8 * i, 1'b0, n);
		// the last lines are still cached and hit at once
		for (int i = N_SEQ - 8; i < N_SEQ; i++) begin
			fetch(64'h1000 + 8 * i, 1'b0, n);
			if (n != 1)
				chk.plain_fail($sformatf("cached line %0d needed %0d cycles", i, n));
		end
		chk.end_test("sequential");

		for (int i = 0; i < N_JUMP; i++) begin
			a = 64'(($urandom % 1024) * 8);
			fetch(a, ($urandom % 4) == 0, n);
		end
		chk.end_test("random_jumps");

		stall_pct = 70;
		for (int i = 0; i < N_STALL; i++)
			fetch(64'h8000 + 8 * i, 1'b0, n);
		stall_pct = 20;
		chk.end_test("memory_stalls");

		// cached lines are presented while disabled, valid must stay low
		@(negedge clk);
		fetch_en_i = 1'b0;
		for (int i = 0; i < 10; i++) begin
			fetch_addr_i = 64'h8000 + 8 * (N_STALL - 1 - i);
			@(negedge clk);
		end
		fetch_en_i = 1'b1;
		for (int i = 0; i < N_DIS; i++)
			fetch(64'h2_0000 + 8 * i, 1'b0, n);
		chk.end_test("fetch_disable");

		chk.summary();
		if (chk.err_total == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// File: compile.f
source/icache_pkg.sv
source/mem_bus_pkg.sv
source/rps4.sv
source/prefetch.sv
source/icache_mem.sv
source/icache_ctrl.sv
source/icache_top.sv
tests/tb_clock.sv
tests/icache_checker.sv
tests/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - source/icache_pkg.sv
  - source/mem_bus_pkg.sv
  - source/rps4.sv
  - source/prefetch.sv
  - source/icache_mem.sv
  - source/icache_ctrl.sv
  - source/icache_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/icache_checker.sv
      - tests/icache_tb.sv
